//--- run_sim.sh
#!/bin/sh
# Builds the shot datapath testbench with Verilator and runs it from the project root.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_shot_unit \
    -f shot_unit.f \
    -o sim_shot_unit

# The verdict comes from the log, so a non-zero exit of the model is not fatal here.
./obj_dir/sim_shot_unit > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression passed" sim.log; then
    exit 0
fi
echo "simulation did not pass, see sim.log"
exit 1

//--- shot_cursor.sv
`timescale 1ns/100ps

module shot_cursor (
    input  logic                           clock,
    input  logic                           rst_n,
    input  logic                           advance,
    input  logic                           scan_clear,
    input  logic                           ship_load,
    input  logic [shot_pkg::coord_w-1:0]   ship_x,
    input  logic [shot_pkg::coord_w-1:0]   ship_y,
    output logic [shot_pkg::slot_w-1:0]    slot,
    output logic                           scan_end,
    output shot_pkg::shot_entry_t          ship_pos
);
    import shot_pkg::*;

    logic [coord_w-1:0] ship_x_q;
    logic [coord_w-1:0] ship_y_q;

    assign scan_end = (slot == slot_w'(slot_count - 1));

    // clear wins over advance, and the last slot wraps back to zero.
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            slot <= '0;
        end else if (scan_clear) begin
            slot <= '0;
        end else if (advance) begin
            if (scan_end) begin
                slot <= '0;
            end else begin
                slot <= slot + slot_w'(1);
            end
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ship_x_q <= ship_home_x;
            ship_y_q <= ship_home_y;
        end else if (ship_load) begin
            ship_x_q <= ship_x;
            ship_y_q <= ship_y;
        end
    end

    // the direction is filled in from fire_dir when a shot is spawned.
    assign ship_pos = '{x: ship_x_q, y: ship_y_q, dir: dir_up};

    a_cursor_controls_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        !$isunknown({advance, scan_clear, ship_load})
    ) else $error("cursor control unknown.");

endmodule

//--- shot_hit_detect.sv
`timescale 1ns/100ps

module shot_hit_detect (
    input  shot_pkg::shot_entry_t         entry,
    input  logic [shot_pkg::coord_w-1:0]  aste_x,
    input  logic [shot_pkg::coord_w-1:0]  aste_y,
    output logic                          x_at_min,
    output logic                          x_at_max,
    output logic                          y_at_min,
    output logic                          y_at_max,
    output logic                          hit
);
    import shot_pkg::*;

    logic x_match;
    logic y_match;

    // border flags tell the controller that the next step leaves the field.
    assign x_at_min = (entry.x == border_min);
    assign x_at_max = (entry.x == border_max);
    assign y_at_min = (entry.y == border_min);
    assign y_at_max = (entry.y == border_max);

    assign x_match = (entry.x == aste_x);
    assign y_match = (entry.y == aste_y);

    // whether the slot is live is the controller's business.
    assign hit = x_match & y_match;

endmodule

//--- shot_pkg.sv
package shot_pkg;

    // the game field is a 16 by 16 grid, so one coordinate fits in four bits.
    localparam int coord_w = 4;

    // one slot per possible shot in flight.
    localparam int slot_count = 16;
    localparam int slot_w = $clog2(slot_count);

    // a shot at these coordinates is about to leave the field.
    localparam logic [coord_w-1:0] border_min = 4'd0;
    localparam logic [coord_w-1:0] border_max = 4'd14;

    // the ship starts in the middle of the field.
    localparam logic [coord_w-1:0] ship_home_x = 4'd7;
    localparam logic [coord_w-1:0] ship_home_y = 4'd7;

    typedef enum logic [1:0] {
        dir_up    = 2'd0,
        dir_down  = 2'd1,
        dir_left  = 2'd2,
        dir_right = 2'd3
    } dir_t;

    // same bit layout as the stored slot word, x in the top bits.
    typedef struct packed {
        logic [coord_w-1:0] x;
        logic [coord_w-1:0] y;
        dir_t               dir;
    } shot_entry_t;

    // where the next value of the current slot comes from.
    typedef enum logic [1:0] {
        src_spawn  = 2'd0,
        src_move_x = 2'd1,
        src_move_y = 2'd2,
        src_keep   = 2'd3
    } src_t;

endpackage

//--- shot_step.sv
`timescale 1ns/100ps

module shot_step (
    input  shot_pkg::shot_entry_t entry,
    input  shot_pkg::shot_entry_t ship_pos,
    input  shot_pkg::dir_t        fire_dir,
    input  shot_pkg::src_t        src,
    input  logic                  axis_y,
    input  logic                  step_down,
    output shot_pkg::shot_entry_t next_entry
);
    import shot_pkg::*;

    logic [coord_w-1:0] coord;
    logic [coord_w-1:0] stepped;

    assign coord = axis_y ? entry.y : entry.x;

    // four-bit arithmetic, so stepping off an edge wraps around the field.
    always_comb begin
        if (step_down) begin
            stepped = coord - coord_w'(1);
        end else begin
            stepped = coord + coord_w'(1);
        end
    end

    always_comb begin
        next_entry = entry;
        case (src)
            src_spawn: begin
                next_entry.x   = ship_pos.x;
                next_entry.y   = ship_pos.y;
                next_entry.dir = fire_dir;
            end
            src_move_x: begin
                next_entry.x = stepped;
            end
            src_move_y: begin
                next_entry.y = stepped;
            end
            default: begin
                next_entry = entry; // keep.
            end
        endcase
    end

endmodule

//--- shot_table.sv
`timescale 1ns/100ps

module shot_table (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic [shot_pkg::slot_w-1:0]   slot,
    input  logic                          write_entry,
    input  shot_pkg::shot_entry_t         next_entry,
    input  logic                          write_loaded,
    input  logic                          loaded_value,
    output shot_pkg::shot_entry_t         entry,
    output logic                          loaded
);
    import shot_pkg::*;

    shot_entry_t            mem [slot_count];
    logic [slot_count-1:0]  loaded_q;

    // the write lands in the slot shown during this cycle, before the cursor moves.
    always_ff @(posedge clock) begin
        if (write_entry) begin
            mem[slot] <= next_entry;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            loaded_q <= '0;
        end else if (write_loaded) begin
            loaded_q[slot] <= loaded_value;
        end
    end

    assign entry  = mem[slot]; // asynchronous read.
    assign loaded = loaded_q[slot];

    a_write_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        !$isunknown({write_entry, write_loaded})
    ) else $error("table write control unknown.");

endmodule

//--- shot_trace.txt
# t adv clr ld sx sy src ax dn dir we wl lv ast_x ast_y | slot end ex ey edir ld xmn xmx ymn ymx hit chk
# all hex; expected values hold in the cycle the line is driven; chk 0 skips entry, flags and hit.
# reset and scan
1  0 0 0 0 0 3 0 0 0 0 0 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   1 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   2 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   3 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   4 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   5 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   6 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   7 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   8 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   9 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   A 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   B 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   C 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   D 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   E 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   F 1 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
1  1 0 0 0 0 3 0 0 0 0 0 0 0 0   1 0 0 0 0 0 0 0 0 0 0 0
1  1 1 0 0 0 3 0 0 0 0 0 0 0 0   2 0 0 0 0 0 0 0 0 0 0 0
# spawn
2  0 0 0 0 0 0 0 0 1 1 0 0 0 0   0 0 0 0 0 0 0 0 0 0 0 0
2  1 0 1 3 9 3 0 0 0 0 0 0 0 0   0 0 7 7 1 0 0 0 0 0 0 1
2  0 0 0 0 0 0 0 0 3 1 0 0 0 0   1 0 0 0 0 0 0 0 0 0 0 0
2  0 0 0 0 0 3 0 0 0 0 0 0 0 0   1 0 3 9 3 0 0 0 0 0 0 1
# movement
3  0 0 0 0 0 1 0 0 0 1 0 0 0 0   1 0 3 9 3 0 0 0 0 0 0 1
3  0 0 0 0 0 2 1 1 0 1 0 0 0 0   1 0 4 9 3 0 0 0 0 0 0 1
3  0 0 0 0 0 3 0 0 0 1 0 0 0 0   1 0 4 8 3 0 0 0 0 0 0 1
3  0 0 1 0 5 3 0 0 0 0 0 0 0 0   1 0 4 8 3 0 0 0 0 0 0 1
3  0 0 0 0 0 0 0 0 2 1 0 0 0 0   1 0 4 8 3 0 0 0 0 0 0 1
3  0 0 0 0 0 1 0 1 0 1 0 0 0 0   1 0 0 5 2 0 1 0 0 0 0 1
# borders
4  0 0 1 E 0 3 0 0 0 0 0 0 0 0   1 0 F 5 2 0 0 0 0 0 0 1
4  0 0 0 0 0 0 0 0 0 1 0 0 0 0   1 0 F 5 2 0 0 0 0 0 0 1
4  0 0 1 E E 3 0 0 0 0 0 0 0 0   1 0 E 0 0 0 0 1 1 0 0 1
4  0 0 0 0 0 0 0 0 1 1 0 0 0 0   1 0 E 0 0 0 0 1 1 0 0 1
# collision and loaded flags
5  0 0 0 0 0 3 0 0 0 0 0 0 E D   1 0 E E 1 0 0 1 0 1 0 1
5  0 0 0 0 0 3 0 0 0 0 0 0 D E   1 0 E E 1 0 0 1 0 1 0 1
5  0 0 0 0 0 3 0 0 0 0 0 0 E E   1 0 E E 1 0 0 1 0 1 1 1
5  0 0 0 0 0 3 0 0 0 0 1 1 0 0   1 0 E E 1 0 0 1 0 1 0 1
5  1 0 0 0 0 3 0 0 0 0 0 0 0 0   1 0 E E 1 1 0 1 0 1 0 1
5  0 0 0 0 0 3 0 0 0 0 1 1 0 0   2 0 0 0 0 0 0 0 0 0 0 0
5  1 0 0 0 0 3 0 0 0 0 0 0 0 0   2 0 0 0 0 1 0 0 0 0 0 0
5  0 1 0 0 0 3 0 0 0 0 0 0 7 7   3 0 0 0 0 0 0 0 0 0 0 0
5  1 0 0 0 0 3 0 0 0 0 0 0 7 7   0 0 7 7 1 0 0 0 0 0 1 1
5  0 0 0 0 0 3 0 0 0 0 1 0 0 0   1 0 E E 1 1 0 1 0 1 0 1
5  1 0 0 0 0 3 0 0 0 0 0 0 0 0   1 0 E E 1 0 0 1 0 1 0 1
# write with advance
6  1 0 0 0 0 0 0 0 2 1 0 0 0 0   2 0 0 0 0 1 0 0 0 0 0 0
6  0 1 0 0 0 3 0 0 0 0 0 0 0 0   3 0 0 0 0 0 0 0 0 0 0 0
6  1 0 0 0 0 3 0 0 0 0 0 0 0 0   0 0 7 7 1 0 0 0 0 0 0 1
6  1 0 0 0 0 3 0 0 0 0 0 0 0 0   1 0 E E 1 0 0 1 0 1 0 1
6  0 0 0 0 0 3 0 0 0 0 0 0 0 0   2 0 E E 2 1 0 1 0 1 0 1

//--- shot_unit.f
shot_pkg.sv
shot_cursor.sv
shot_step.sv
shot_table.sv
shot_hit_detect.sv
shot_unit.sv
tb_shot_unit.sv

//--- shot_unit.sv
`timescale 1ns/100ps

module shot_unit (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          advance,
    input  logic                          scan_clear,
    input  logic                          ship_load,
    input  logic [shot_pkg::coord_w-1:0]  ship_x,
    input  logic [shot_pkg::coord_w-1:0]  ship_y,
    input  shot_pkg::src_t                src,
    input  logic                          axis_y,
    input  logic                          step_down,
    input  shot_pkg::dir_t                fire_dir,
    input  logic                          write_entry,
    input  logic                          write_loaded,
    input  logic                          loaded_value,
    input  logic [shot_pkg::coord_w-1:0]  aste_x,
    input  logic [shot_pkg::coord_w-1:0]  aste_y,
    output logic [shot_pkg::slot_w-1:0]   slot,
    output logic                          scan_end,
    output shot_pkg::shot_entry_t         entry,
    output logic                          loaded,
    output logic                          x_at_min,
    output logic                          x_at_max,
    output logic                          y_at_min,
    output logic                          y_at_max,
    output logic                          hit
);
    import shot_pkg::*;

    shot_entry_t ship_pos;
    shot_entry_t next_entry;

    shot_cursor cursor0 (
        .clock      (clock),
        .rst_n      (rst_n),
        .advance    (advance),
        .scan_clear (scan_clear),
        .ship_load  (ship_load),
        .ship_x     (ship_x),
        .ship_y     (ship_y),
        .slot       (slot),
        .scan_end   (scan_end),
        .ship_pos   (ship_pos)
    );

    shot_step step0 (
        .entry      (entry),
        .ship_pos   (ship_pos),
        .fire_dir   (fire_dir),
        .src        (src),
        .axis_y     (axis_y),
        .step_down  (step_down),
        .next_entry (next_entry)
    );

    shot_table table0 (
        .clock        (clock),
        .rst_n        (rst_n),
        .slot         (slot),
        .write_entry  (write_entry),
        .next_entry   (next_entry),
        .write_loaded (write_loaded),
        .loaded_value (loaded_value),
        .entry        (entry),
        .loaded       (loaded)
    );

    shot_hit_detect hit0 (
        .entry    (entry),
        .aste_x   (aste_x),
        .aste_y   (aste_y),
        .x_at_min (x_at_min),
        .x_at_max (x_at_max),
        .y_at_min (y_at_min),
        .y_at_max (y_at_max),
        .hit      (hit)
    );

    // the step logic has no clock of its own, so its source select is checked here.
    a_src_known: assert property (
        @(posedge clock) disable iff (!rst_n)
        write_entry |-> !$isunknown(src)
    ) else $error("src unknown during an entry write.");

endmodule

//--- tb_shot_unit.sv
`timescale 1ns/100ps

module tb_shot_unit;
    import shot_pkg::*;

    localparam int field_count = 27;
    localparam int max_lines = 200;
    localparam int max_cycles = 400;

    logic               clock;
    logic               rst_n;
    logic               advance;
    logic               scan_clear;
    logic               ship_load;
    logic [coord_w-1:0] ship_x;
    logic [coord_w-1:0] ship_y;
    src_t               src;
    logic               axis_y;
    logic               step_down;
    dir_t               fire_dir;
    logic               write_entry;
    logic               write_loaded;
    logic               loaded_value;
    logic [coord_w-1:0] aste_x;
    logic [coord_w-1:0] aste_y;
    logic [slot_w-1:0]  slot;
    logic               scan_end;
    shot_entry_t        entry;
    logic               loaded;
    logic               x_at_min;
    logic               x_at_max;
    logic               y_at_min;
    logic               y_at_max;
    logic               hit;

    int                 fields [field_count];
    int                 fd;
    int                 cur_test;
    int                 test_errors;
    int                 test_count;
    int                 check_count;
    int                 error_count;
    bit                 run_done;
    logic [8*160-1:0]   skip_buf;

    shot_unit dut0 (
        .clock        (clock),
        .rst_n        (rst_n),
        .advance      (advance),
        .scan_clear   (scan_clear),
        .ship_load    (ship_load),
        .ship_x       (ship_x),
        .ship_y       (ship_y),
        .src          (src),
        .axis_y       (axis_y),
        .step_down    (step_down),
        .fire_dir     (fire_dir),
        .write_entry  (write_entry),
        .write_loaded (write_loaded),
        .loaded_value (loaded_value),
        .aste_x       (aste_x),
        .aste_y       (aste_y),
        .slot         (slot),
        .scan_end     (scan_end),
        .entry        (entry),
        .loaded       (loaded),
        .x_at_min     (x_at_min),
        .x_at_max     (x_at_max),
        .y_at_min     (y_at_min),
        .y_at_max     (y_at_max),
        .hit          (hit)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    function automatic string test_name(input int id);
        case (id)
            1: return "reset_and_scan";
            2: return "spawn";
            3: return "movement";
            4: return "borders";
            5: return "collision_and_loaded";
            6: return "write_with_advance";
            default: return "unknown";
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            test_errors++;
            $display("Fail %s %s: expected %h, actual %h", test_name(cur_test), name,
                     expected, actual);
        end
    endtask

    task automatic drive_idle();
        advance      = 1'b0;
        scan_clear   = 1'b0;
        ship_load    = 1'b0;
        ship_x       = '0;
        ship_y       = '0;
        src          = src_keep;
        axis_y       = 1'b0;
        step_down    = 1'b0;
        fire_dir     = dir_up;
        write_entry  = 1'b0;
        write_loaded = 1'b0;
        loaded_value = 1'b0;
        aste_x       = '0;
        aste_y       = '0;
    endtask

    task automatic drive_record();
        advance      = fields[1][0];
        scan_clear   = fields[2][0];
        ship_load    = fields[3][0];
        ship_x       = fields[4][coord_w-1:0];
        ship_y       = fields[5][coord_w-1:0];
        src          = src_t'(fields[6][1:0]);
        axis_y       = fields[7][0];
        step_down    = fields[8][0];
        fire_dir     = dir_t'(fields[9][1:0]);
        write_entry  = fields[10][0];
        write_loaded = fields[11][0];
        loaded_value = fields[12][0];
        aste_x       = fields[13][coord_w-1:0];
        aste_y       = fields[14][coord_w-1:0];
    endtask

    // entry and the flags that follow it are skipped while the slot is still unwritten.
    task automatic check_record();
        check_value("slot", fields[15], 32'(slot));
        check_value("scan_end", fields[16], 32'(scan_end));
        check_value("loaded", fields[20], 32'(loaded));
        if (fields[26] != 0) begin
            check_value("entry",
                        32'({fields[17][3:0], fields[18][3:0], fields[19][1:0]}),
                        32'(entry));
            check_value("x_at_min", fields[21], 32'(x_at_min));
            check_value("x_at_max", fields[22], 32'(x_at_max));
            check_value("y_at_min", fields[23], 32'(y_at_min));
            check_value("y_at_max", fields[24], 32'(y_at_max));
            check_value("hit", fields[25], 32'(hit));
        end
    endtask

    task automatic close_test();
        if (cur_test != 0) begin
            test_count++;
            if (test_errors == 0) begin
                $display("test %s: ok", test_name(cur_test));
            end else begin
                $display("test %s: %0d errors", test_name(cur_test), test_errors);
            end
        end
    endtask

    task automatic read_rest(output int got);
        int i;
        int r;
        got = 0;
        for (i = 1; i < field_count; i++) begin
            r = $fscanf(fd, "%h", fields[i]);
            if (r == 1) begin
                got++;
            end
        end
    endtask

    // inputs go in just after the edge, outputs are sampled just before the next one.
    task automatic replay_trace();
        int  lines;
        int  r;
        int  got;
        bit  at_end;
        lines  = 0;
        at_end = 1'b0;
        while (!at_end && lines < max_lines) begin
            lines++;
            r = $fscanf(fd, "%h", fields[0]);
            if (r == 1) begin
                read_rest(got);
                if (got == field_count - 1) begin
                    if (fields[0] != cur_test) begin
                        close_test();
                        cur_test    = fields[0];
                        test_errors = 0;
                    end
                    @(posedge clock);
                    #1;
                    drive_record();
                    #8;
                    check_record();
                end else begin
                    $display("trace record %0d has missing fields.", lines);
                    error_count++;
                    at_end = 1'b1;
                end
            end else if (r == 0) begin
                r = $fgets(skip_buf, fd); // a comment line.
                if (r == 0) begin
                    at_end = 1'b1;
                end
            end else begin
                at_end = 1'b1;
            end
        end
        if (!at_end) begin
            $display("the trace did not end within %0d lines.", max_lines);
            error_count++;
        end
    endtask

    initial begin
        int cycles;
        cycles = 0;
        while (!run_done && cycles < max_cycles) begin
            @(posedge clock);
            cycles++;
        end
        if (!run_done) begin
            $display("timeout: the trace replay did not finish within %0d cycles.", max_cycles);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        run_done    = 1'b0;
        cur_test    = 0;
        test_errors = 0;
        test_count  = 0;
        check_count = 0;
        error_count = 0;
        rst_n       = 1'b0;
        drive_idle();
        repeat (2) @(posedge clock);
        #1 rst_n = 1'b1;
        fd = $fopen("shot_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file shot_trace.txt.");
            error_count++;
        end else begin
            replay_trace();
            $fclose(fd);
        end
        close_test();
        if (check_count == 0) begin
            $display("no trace records were replayed.");
            error_count++;
        end
        $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
        run_done = 1'b1;
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
